//--- Bender.yml
package:
  name: avmm_mem_subsys

sources:
  - common/avmm_pkg.sv
  - avmm_reg/avmm_reg_pipe.sv
  - src/avmm_req_queue.sv
  - src/avmm_mem_responder.sv
  - src/avmm_mem_subsys.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/avmm_mem_subsys_tb.sv

//--- avmm_reg/avmm_reg_pipe.sv
////////////////////////////////////////////////////////////
// Avalon-MM register pipeline
// Almost-full waitrequest handshake
////////////////////////////////////////////////////////////

`default_nettype none

module avmm_reg_pipe #(
    // Register stages on the request and response paths (one or more)
    parameter int unsigned N_REG_STAGES         = 2,
    // Stages on the waitrequest path from the queue back to the host
    parameter int unsigned N_WAITREQUEST_STAGES = N_REG_STAGES
) (
    input  logic                mem_slave,
    input  logic                rst_n,

    // Host side
    input  avmm_pkg::avmm_req_t host_req,
    output logic                host_waitrequest,
    output avmm_pkg::avmm_rsp_t host_rsp,

    // Queue side
    output avmm_pkg::avmm_req_t q_req,
    input  logic                q_waitrequest,
    input  avmm_pkg::avmm_rsp_t mem_rsp
);

    // Request as it enters the first register stage
    // Only accepted requests keep their read or write bit
    avmm_pkg::avmm_req_t req_in;

    // Forward request stages where the last one drives the queue
    avmm_pkg::avmm_req_t req_pipe [1:N_REG_STAGES];

    // Backward response stages where the last one drives the host
    avmm_pkg::avmm_rsp_t rsp_pipe [1:N_REG_STAGES];

    // Delayed copies of the queue waitrequest
    // Bit 1 is one cycle old and the top bit is seen by the host
    logic [N_WAITREQUEST_STAGES:1] wait_pipe;

    // The host sees waitrequest only after the full delay
    assign host_waitrequest = wait_pipe[N_WAITREQUEST_STAGES];

    // A held request under waitrequest must not enter the pipeline
    // because it would otherwise be pushed again once waitrequest drops
    always_comb
    begin
        req_in       = host_req;
        req_in.read  = host_req.read & ~host_waitrequest;
        req_in.write = host_req.write & ~host_waitrequest;
    end

    // Request path toward the queue
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Every stage is emptied so no stray read or write reaches the queue
            for (int s = 1; s <= N_REG_STAGES; s++)
            begin
                req_pipe[s] <= '0;
            end
        end
        else
        begin
            req_pipe[1] <= req_in;
            for (int s = 2; s <= N_REG_STAGES; s++)
            begin
                req_pipe[s] <= req_pipe[s-1];
            end
        end
    end

    assign q_req = req_pipe[N_REG_STAGES];

    // Response path toward the host with the same depth as the request path
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 1; s <= N_REG_STAGES; s++)
            begin
                rsp_pipe[s] <= '0;
            end
        end
        else
        begin
            rsp_pipe[1] <= mem_rsp;
            for (int s = 2; s <= N_REG_STAGES; s++)
            begin
                rsp_pipe[s] <= rsp_pipe[s-1];
            end
        end
    end

    assign host_rsp = rsp_pipe[N_REG_STAGES];

    // Waitrequest shift register
    // It reloads all ones so that the host is stalled until the
    // queue has reported room through every stage
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wait_pipe <= '1;
        end
        else
        begin
            wait_pipe[1] <= q_waitrequest;
            for (int s = 2; s <= N_WAITREQUEST_STAGES; s++)
            begin
                wait_pipe[s] <= wait_pipe[s-1];
            end
        end
    end

    // The host never asks for a read and a write in the same slot
    a_no_read_and_write: assert property (
        @(posedge mem_slave) disable iff (!rst_n)
        !(host_req.read && host_req.write)
    );

endmodule

`default_nettype wire

//--- common/avmm_pkg.sv
////////////////////////////////////////////////////////////
// Avalon-MM memory subsystem shared types
////////////////////////////////////////////////////////////

`default_nettype none

package avmm_pkg;

    // Word address width, one address selects one full data word
    localparam int unsigned ADDR_W = 8;

    // Data word width, must be a whole number of bytes
    localparam int unsigned DATA_W = 32;

    // One byte enable per data byte
    localparam int unsigned BE_W = DATA_W / 8;

    // Word address as seen by the host and the memory
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

    // Byte lane enables, bit n covers data bits 8n+7 down to 8n
    typedef logic [BE_W-1:0] byteen_t;

    // Host request toward the memory
    // Read and write are never both set, and a request with neither
    // set is an idle slot that carries no meaning
    typedef struct packed {
        logic    read;
        logic    write;
        addr_t   address;
        data_t   writedata;
        byteen_t byteenable;
    } avmm_req_t;

    // Read response toward the host
    // Writes produce no response, so only reads return here
    typedef struct packed {
        logic  readdatavalid;
        data_t readdata;
    } avmm_rsp_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+tests
common/avmm_pkg.sv
avmm_reg/avmm_reg_pipe.sv
src/avmm_req_queue.sv
src/avmm_mem_responder.sv
src/avmm_mem_subsys.sv
tests/avmm_mem_subsys_tb.sv

//--- src/avmm_mem_responder.sv
////////////////////////////////////////////////////////////
// On-chip memory responder with refresh
////////////////////////////////////////////////////////////

`default_nettype none

module avmm_mem_responder #(
    // Cycles from the pop of a read to its response (one or more)
    parameter int unsigned READ_LATENCY   = 2,
    // Length of one serve plus refresh cycle
    parameter int unsigned REFRESH_PERIOD = 32,
    // Cycles spent in refresh within each period
    parameter int unsigned REFRESH_CYCLES = 6
) (
    input  logic                mem_slave,
    input  logic                rst_n,

    input  avmm_pkg::avmm_req_t head_req,
    input  logic                head_valid,
    output logic                pop_ready,

    output avmm_pkg::avmm_rsp_t mem_rsp
);

    localparam int unsigned SERVE_CYCLES = REFRESH_PERIOD - REFRESH_CYCLES;
    localparam int unsigned CNT_W        = $clog2(REFRESH_PERIOD);
    localparam int unsigned WORDS        = 2 ** avmm_pkg::ADDR_W;

    // Refresh must leave some serve time in every period
    if (REFRESH_PERIOD <= REFRESH_CYCLES)
    begin : g_period_check
        $error("REFRESH_PERIOD must exceed REFRESH_CYCLES");
    end

    typedef enum logic {
        st_serve,
        st_refresh
    } resp_state_t;

    resp_state_t      state;
    logic [CNT_W-1:0] phase_cnt;
    logic             pop;

    // The word array holds only what the host has written
    avmm_pkg::data_t mem [WORDS];

    // The last stage of the read valid and data pipeline drives the response
    logic [READ_LATENCY:1] rd_valid;
    avmm_pkg::data_t       rd_data [1:READ_LATENCY];

    assign pop_ready = (state == st_serve);
    assign pop       = head_valid & pop_ready;

    // Serve and refresh alternate and the phase counter restarts at each
    // change, so the two windows together span one refresh period
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_serve;
            phase_cnt <= '0;
        end
        else
        begin
            case (state)
                st_serve:
                begin
                    if (phase_cnt == CNT_W'(SERVE_CYCLES - 1))
                    begin
                        state     <= st_refresh;
                        phase_cnt <= '0;
                    end
                    else
                    begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                default:
                begin
                    if (phase_cnt == CNT_W'(REFRESH_CYCLES - 1))
                    begin
                        state     <= st_serve;
                        phase_cnt <= '0;
                    end
                    else
                    begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Byte-enabled write merge and read data capture
    // A read popped right after a write to the same word sees new data
    always_ff @(posedge mem_slave)
    begin
        if (pop && head_req.write)
        begin
            for (int b = 0; b < avmm_pkg::BE_W; b++)
            begin
                if (head_req.byteenable[b])
                begin
                    mem[head_req.address][8*b +: 8] <= head_req.writedata[8*b +: 8];
                end
            end
        end
        rd_data[1] <= mem[head_req.address];
        for (int s = 2; s <= READ_LATENCY; s++)
        begin
            rd_data[s] <= rd_data[s-1];
        end
    end

    // The valid bits follow each popped read through the latency stages
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_valid <= '0;
        end
        else
        begin
            rd_valid[1] <= pop & head_req.read;
            for (int s = 2; s <= READ_LATENCY; s++)
            begin
                rd_valid[s] <= rd_valid[s-1];
            end
        end
    end

    always_comb
    begin
        mem_rsp.readdatavalid = rd_valid[READ_LATENCY];
        mem_rsp.readdata      = rd_data[READ_LATENCY];
    end

    // Nothing is popped for the whole refresh window
    a_no_pop_in_refresh: assert property (
        @(posedge mem_slave) disable iff (!rst_n)
        $rose(state == st_refresh) |-> !pop [*REFRESH_CYCLES]
    );

endmodule

`default_nettype wire

//--- src/avmm_mem_subsys.sv
////////////////////////////////////////////////////////////
// Avalon-MM memory subsystem top level
////////////////////////////////////////////////////////////

`default_nettype none

module avmm_mem_subsys #(
    parameter int unsigned N_REG_STAGES         = 2,
    parameter int unsigned N_WAITREQUEST_STAGES = N_REG_STAGES,
    parameter int unsigned QUEUE_DEPTH          = 8,
    parameter int unsigned READ_LATENCY         = 2,
    parameter int unsigned REFRESH_PERIOD       = 32,
    parameter int unsigned REFRESH_CYCLES       = 6
) (
    input  logic                mem_slave,
    input  logic                rst_n,

    // Host port, one single-word request per accepted cycle
    input  avmm_pkg::avmm_req_t host_req,
    output logic                host_waitrequest,
    output avmm_pkg::avmm_rsp_t host_rsp
);

    // Pipeline to queue
    avmm_pkg::avmm_req_t q_req;
    logic                q_waitrequest;

    // Queue to responder
    avmm_pkg::avmm_req_t head_req;
    logic                head_valid;
    logic                pop_ready;

    // Responder back to the pipeline
    avmm_pkg::avmm_rsp_t mem_rsp;

    // Register stages between the host and the queue
    avmm_reg_pipe #(
        .N_REG_STAGES        (N_REG_STAGES),
        .N_WAITREQUEST_STAGES(N_WAITREQUEST_STAGES)
    ) avmm_reg_pipe_inst (
        .mem_slave       (mem_slave),
        .rst_n           (rst_n),
        .host_req        (host_req),
        .host_waitrequest(host_waitrequest),
        .host_rsp        (host_rsp),
        .q_req           (q_req),
        .q_waitrequest   (q_waitrequest),
        .mem_rsp         (mem_rsp)
    );

    // The queue sizes its slack from the same stage counts
    avmm_req_queue #(
        .QUEUE_DEPTH         (QUEUE_DEPTH),
        .N_REG_STAGES        (N_REG_STAGES),
        .N_WAITREQUEST_STAGES(N_WAITREQUEST_STAGES)
    ) avmm_req_queue_inst (
        .mem_slave    (mem_slave),
        .rst_n        (rst_n),
        .q_req        (q_req),
        .q_waitrequest(q_waitrequest),
        .head_req     (head_req),
        .head_valid   (head_valid),
        .pop_ready    (pop_ready)
    );

    avmm_mem_responder #(
        .READ_LATENCY  (READ_LATENCY),
        .REFRESH_PERIOD(REFRESH_PERIOD),
        .REFRESH_CYCLES(REFRESH_CYCLES)
    ) avmm_mem_responder_inst (
        .mem_slave (mem_slave),
        .rst_n     (rst_n),
        .head_req  (head_req),
        .head_valid(head_valid),
        .pop_ready (pop_ready),
        .mem_rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

//--- src/avmm_req_queue.sv
////////////////////////////////////////////////////////////
// Request queue with almost-full waitrequest
////////////////////////////////////////////////////////////

`default_nettype none

module avmm_req_queue #(
    parameter int unsigned QUEUE_DEPTH          = 8,
    parameter int unsigned N_REG_STAGES         = 2,
    parameter int unsigned N_WAITREQUEST_STAGES = N_REG_STAGES
) (
    input  logic                mem_slave,
    input  logic                rst_n,

    // Push side from the register pipeline
    input  avmm_pkg::avmm_req_t q_req,
    output logic                q_waitrequest,

    // Pop side toward the responder
    output avmm_pkg::avmm_req_t head_req,
    output logic                head_valid,
    input  logic                pop_ready
);

    // Requests that may still arrive after waitrequest is raised:
    // one per forward stage, one per delayed waitrequest stage and
    // one for the registered waitrequest itself
    localparam int unsigned SLACK = N_REG_STAGES + N_WAITREQUEST_STAGES + 1;
    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    // A queue no deeper than the slack could never lower waitrequest
    if (QUEUE_DEPTH <= SLACK)
    begin : g_depth_check
        $error("QUEUE_DEPTH must exceed the in-flight slack");
    end

    // Entry storage, contents are meaningless until written
    avmm_pkg::avmm_req_t entries [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    // The pipeline only forwards accepted requests, so every valid
    // one is taken without asking
    assign push = q_req.read | q_req.write;
    assign pop  = head_valid & pop_ready;

    assign head_valid = (count != '0);
    assign head_req   = entries[rd_ptr];

    always_comb
    begin
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            entries[wr_ptr] <= q_req;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            q_waitrequest <= 1'b1;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Stall while the free entries only just cover what is in flight
            q_waitrequest <= (CNT_W'(QUEUE_DEPTH) - count_next) <= CNT_W'(SLACK);
        end
    end

    // The slack must absorb every in-flight request
    a_no_overflow: assert property (
        @(posedge mem_slave) disable iff (!rst_n)
        push |-> (count != CNT_W'(QUEUE_DEPTH))
    );

    // An empty queue has both pointers on the same entry
    a_empty_pointers: assert property (
        @(posedge mem_slave) disable iff (!rst_n)
        (count == '0) |-> (rd_ptr == wr_ptr)
    );

endmodule

`default_nettype wire

//--- tests/avmm_tb_table.svh
////////////////////////////////////////////////////////////
// Directed stimulus table
////////////////////////////////////////////////////////////

`ifndef AVMM_TB_TABLE_SVH
`define AVMM_TB_TABLE_SVH

// Each entry holds operation, address, writedata, byteenable and expected read data
localparam logic [1:0] OP_WRITE = 2'd1;
localparam logic [1:0] OP_READ  = 2'd2;

typedef struct packed {
    logic [1:0]        op;
    avmm_pkg::addr_t   addr;
    avmm_pkg::data_t   wdata;
    avmm_pkg::byteen_t be;
    avmm_pkg::data_t   rdata;
} table_entry_t;

localparam int unsigned TABLE_LEN = 24;

table_entry_t op_table [TABLE_LEN];

task automatic fill_table();
    // Full-word writes, then reads of the same words in order
    op_table[0]  = '{OP_WRITE, 8'h10, 32'h1122_3344, 4'b1111, 32'h0000_0000};
    op_table[1]  = '{OP_WRITE, 8'h11, 32'hA5A5_5A5A, 4'b1111, 32'h0000_0000};
    op_table[2]  = '{OP_WRITE, 8'h12, 32'hDEAD_BEEF, 4'b1111, 32'h0000_0000};
    op_table[3]  = '{OP_WRITE, 8'hFF, 32'h0BAD_F00D, 4'b1111, 32'h0000_0000};
    op_table[4]  = '{OP_READ,  8'h10, 32'h0000_0000, 4'b0000, 32'h1122_3344};
    op_table[5]  = '{OP_READ,  8'h11, 32'h0000_0000, 4'b0000, 32'hA5A5_5A5A};
    op_table[6]  = '{OP_READ,  8'h12, 32'h0000_0000, 4'b0000, 32'hDEAD_BEEF};
    op_table[7]  = '{OP_READ,  8'hFF, 32'h0000_0000, 4'b0000, 32'h0BAD_F00D};
    // Partial writes merge into words that already hold data
    op_table[8]  = '{OP_WRITE, 8'h10, 32'hCAFE_0000, 4'b1100, 32'h0000_0000};
    op_table[9]  = '{OP_WRITE, 8'h11, 32'h0000_00FF, 4'b0001, 32'h0000_0000};
    op_table[10] = '{OP_WRITE, 8'h12, 32'h1277_5566, 4'b0100, 32'h0000_0000};
    op_table[11] = '{OP_READ,  8'h10, 32'h0000_0000, 4'b0000, 32'hCAFE_3344};
    op_table[12] = '{OP_READ,  8'h11, 32'h0000_0000, 4'b0000, 32'hA5A5_5AFF};
    op_table[13] = '{OP_READ,  8'h12, 32'h0000_0000, 4'b0000, 32'hDE77_BEEF};
    // Writes and reads interleaved on one word, each read sees only earlier writes
    op_table[14] = '{OP_WRITE, 8'h20, 32'h0000_0001, 4'b1111, 32'h0000_0000};
    op_table[15] = '{OP_READ,  8'h20, 32'h0000_0000, 4'b0000, 32'h0000_0001};
    op_table[16] = '{OP_WRITE, 8'h20, 32'h0000_00AB, 4'b0001, 32'h0000_0000};
    op_table[17] = '{OP_READ,  8'h20, 32'h0000_0000, 4'b0000, 32'h0000_00AB};
    op_table[18] = '{OP_WRITE, 8'h20, 32'h1234_0000, 4'b1000, 32'h0000_0000};
    op_table[19] = '{OP_READ,  8'h20, 32'h0000_0000, 4'b0000, 32'h1200_00AB};
    // No byte enabled, so the word stays as it was
    op_table[20] = '{OP_WRITE, 8'h20, 32'hFFFF_FFFF, 4'b0000, 32'h0000_0000};
    op_table[21] = '{OP_READ,  8'h20, 32'h0000_0000, 4'b0000, 32'h1200_00AB};
    op_table[22] = '{OP_WRITE, 8'hFF, 32'h4433_2211, 4'b0011, 32'h0000_0000};
    op_table[23] = '{OP_READ,  8'hFF, 32'h0000_0000, 4'b0000, 32'h0BAD_2211};
endtask

`endif

//--- tests/avmm_mem_subsys_tb.sv
////////////////////////////////////////////////////////////
// Avalon-MM memory subsystem testbench
////////////////////////////////////////////////////////////

`default_nettype none

module avmm_mem_subsys_tb;

    localparam int unsigned N_REG_STAGES         = 2;
    localparam int unsigned N_WAITREQUEST_STAGES = N_REG_STAGES;
    localparam int unsigned QUEUE_DEPTH          = 8;
    localparam int unsigned READ_LATENCY         = 2;
    localparam int unsigned REFRESH_PERIOD       = 32;
    localparam int unsigned REFRESH_CYCLES       = 6;

    `include "avmm_tb_table.svh"

    // Random phase sizes, the primed words keep reads away from unwritten memory
    localparam int unsigned RAND_SEED   = 75;
    localparam int unsigned PRIME_WORDS = 16;
    localparam int unsigned MIX_COUNT   = 200;
    localparam int unsigned RAND_BASE   = 8'h40;

    // Worst case per request covers a full queue, a refresh and both pipelines
    localparam int unsigned TIMEOUT_CYCLES = (TABLE_LEN + PRIME_WORDS + MIX_COUNT) *
        (QUEUE_DEPTH + REFRESH_CYCLES + 2 * N_REG_STAGES + READ_LATENCY + 4);

    logic                mem_slave;
    logic                rst_n;
    avmm_pkg::avmm_req_t host_req;
    logic                host_waitrequest;
    avmm_pkg::avmm_rsp_t host_rsp;

    // Reference memory and the read data expected back, oldest first
    avmm_pkg::data_t ref_mem [2**avmm_pkg::ADDR_W];
    avmm_pkg::data_t exp_q [$];
    avmm_pkg::data_t rsp_expected;

    int unsigned error_count;
    int unsigned cycle_count;
    int unsigned reads_accepted;
    int unsigned rsp_count;
    logic        wait_dropped;
    logic        wait_rise_seen;

    avmm_mem_subsys #(
        .N_REG_STAGES        (N_REG_STAGES),
        .N_WAITREQUEST_STAGES(N_WAITREQUEST_STAGES),
        .QUEUE_DEPTH         (QUEUE_DEPTH),
        .READ_LATENCY        (READ_LATENCY),
        .REFRESH_PERIOD      (REFRESH_PERIOD),
        .REFRESH_CYCLES      (REFRESH_CYCLES)
    ) avmm_mem_subsys_inst (
        .mem_slave       (mem_slave),
        .rst_n           (rst_n),
        .host_req        (host_req),
        .host_waitrequest(host_waitrequest),
        .host_rsp        (host_rsp)
    );

    always #2 mem_slave = ~mem_slave;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] time %0t %s expected 0x%08h got 0x%08h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Bytes with their enable set take the new data, the rest keep the old word
    function automatic avmm_pkg::data_t merge_bytes(input avmm_pkg::data_t old_word,
                                                    input avmm_pkg::data_t new_word,
                                                    input avmm_pkg::byteen_t be);
        avmm_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < avmm_pkg::BE_W; b++)
        begin
            if (be[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Drives one request at 1 unit past the edge and holds it until a cycle
    // with waitrequest low, then books it in the reference model
    task automatic issue_request(input logic [1:0] op, input avmm_pkg::addr_t addr,
                                 input avmm_pkg::data_t wdata,
                                 input avmm_pkg::byteen_t be,
                                 input avmm_pkg::data_t table_rdata,
                                 input logic from_table);
        logic accepted;
        host_req.read       = (op == OP_READ);
        host_req.write      = (op == OP_WRITE);
        host_req.address    = addr;
        host_req.writedata  = wdata;
        host_req.byteenable = be;
        accepted = 1'b0;
        while (!accepted)
        begin
            // Waitrequest is registered, so mid-cycle it is settled
            @(negedge mem_slave);
            accepted = !host_waitrequest;
            @(posedge mem_slave);
            #1;
        end
        if (op == OP_WRITE)
        begin
            ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, be);
        end
        else
        begin
            reads_accepted++;
            if (from_table)
            begin
                // The hand-written expectation must agree with the model
                check_value("table_rdata", ref_mem[addr], table_rdata);
                exp_q.push_back(table_rdata);
            end
            else
            begin
                exp_q.push_back(ref_mem[addr]);
            end
        end
    endtask

    // Response and waitrequest monitor, sampled on the falling edge
    always @(negedge mem_slave)
    begin
        if (rst_n)
        begin
            if (!host_waitrequest)
            begin
                wait_dropped = 1'b1;
            end
            else if (wait_dropped)
            begin
                wait_rise_seen = 1'b1;
            end
            if (host_rsp.readdatavalid)
            begin
                rsp_count++;
                if (exp_q.size() == 0)
                begin
                    $display("Read response at time %0t with no read outstanding", $time);
                    error_count++;
                end
                else
                begin
                    rsp_expected = exp_q.pop_front();
                    check_value("host_rsp.readdata", rsp_expected, host_rsp.readdata);
                end
            end
        end
    end

    always @(posedge mem_slave)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        int unsigned seed_state;
        logic [1:0]  mix_op;
        mem_slave      = 1'b0;
        rst_n          = 1'b0;
        host_req       = '0;
        error_count    = 0;
        cycle_count    = 0;
        reads_accepted = 0;
        rsp_count      = 0;
        wait_dropped   = 1'b0;
        wait_rise_seen = 1'b0;
        seed_state     = $urandom(RAND_SEED);
        fill_table();

        repeat (3) @(posedge mem_slave);
        #1;
        rst_n = 1'b1;

        // Straight after reset the host is stalled and nothing is returned
        @(negedge mem_slave);
        check_value("host_waitrequest", 32'd1, {31'd0, host_waitrequest});
        check_value("host_rsp.readdatavalid", 32'd0, {31'd0, host_rsp.readdatavalid});
        // Waitrequest must drop on its own with the host idle
        while (host_waitrequest)
        begin
            @(negedge mem_slave);
        end
        @(posedge mem_slave);
        #1;

        // Directed phase
        for (int i = 0; i < TABLE_LEN; i++)
        begin
            issue_request(op_table[i].op, op_table[i].addr, op_table[i].wdata,
                          op_table[i].be, op_table[i].rdata, 1'b1);
        end

        // Random phase runs back to back so refresh windows build back-pressure
        for (int i = 0; i < PRIME_WORDS; i++)
        begin
            issue_request(OP_WRITE, avmm_pkg::addr_t'(RAND_BASE + i), $urandom(),
                          4'b1111, '0, 1'b0);
        end
        for (int i = 0; i < MIX_COUNT; i++)
        begin
            mix_op = ($urandom() % 2 == 0) ? OP_READ : OP_WRITE;
            issue_request(mix_op, avmm_pkg::addr_t'(RAND_BASE + ($urandom() % PRIME_WORDS)),
                          $urandom(), avmm_pkg::byteen_t'($urandom()), '0, 1'b0);
        end
        host_req = '0;

        // Drain outstanding reads, then watch a little longer for stray pulses
        while (exp_q.size() != 0)
        begin
            @(posedge mem_slave);
        end
        repeat (2 * N_REG_STAGES + READ_LATENCY + 4) @(posedge mem_slave);

        check_value("readdatavalid_count", reads_accepted, rsp_count);
        check_value("host_waitrequest_rise", 32'd1, {31'd0, wait_rise_seen});

        $display("Run finished with %0d errors over %0d reads", error_count, reads_accepted);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
